// ==== logic/scope_pkg.sv ====
// **********************************************************************
// Scope capture package
// Widths, register map and trigger states shared by the capture
// engine blocks
// **********************************************************************
package scope_pkg;

    // One channel sample, compared as unsigned
    typedef logic [15:0] sample_t;

    // Combined stream word: channel index above, sample below
    typedef logic [31:0] word_t;

    // Simple bus register address
    typedef logic [3:0] reg_addr_t;

    // Register map of the configuration bank
    localparam reg_addr_t ADDR_FRAME_LENGTH = 4'd0;
    localparam reg_addr_t ADDR_ENABLE       = 4'd1;
    localparam reg_addr_t ADDR_TRIG_LEVEL   = 4'd2;
    localparam reg_addr_t ADDR_TRIG_CHANNEL = 4'd3;

    // Trigger FSM states
    typedef enum logic {
        ARMED,
        CAPTURING
    } trig_state_t;

endpackage

// ==== logic/channel_combiner.sv ====
// **********************************************************************
// Channel combiner
// Holds one pending sample per channel and merges them into a single
// tagged word strobe, picking channels round-robin
// **********************************************************************
`timescale 1ns/1ps

module channel_combiner #(
    parameter N_CHANNELS = 4
) (
    input  logic                clock,
    input  logic                rst,
    input  logic [N_CHANNELS-1:0] ch_valid,
    input  scope_pkg::sample_t  ch_data [N_CHANNELS],
    output logic                comb_valid,
    output scope_pkg::word_t    comb_data,
    output logic                overrun
);

    localparam PTR_W = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

    logic [N_CHANNELS-1:0] pending_q;
    scope_pkg::sample_t    sample_q [N_CHANNELS];
    logic [PTR_W-1:0]      last_ch;
    logic [PTR_W-1:0]      sel_ch;

    // Search starts just after the channel emitted last
    always_comb begin
        int unsigned idx;
        comb_valid = 1'b0;
        sel_ch = last_ch;
        for (int k = 1; k <= N_CHANNELS; k++) begin
            idx = int'(last_ch) + k;
            if (idx >= N_CHANNELS) begin
                idx = idx - N_CHANNELS;
            end
            if (!comb_valid && pending_q[idx]) begin
                comb_valid = 1'b1;
                sel_ch = PTR_W'(idx);
            end
        end
    end

    assign comb_data = {16'(sel_ch), sample_q[sel_ch]};

    // Sample storage follows the strobes directly
    always_ff @(posedge clock) begin
        for (int i = 0; i < N_CHANNELS; i++) begin
            if (ch_valid[i]) begin
                sample_q[i] <= ch_data[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            pending_q <= '0;
            last_ch <= PTR_W'(N_CHANNELS - 1);
            overrun <= 1'b0;
        end else begin
            if (comb_valid) begin
                last_ch <= sel_ch;
            end
            for (int i = 0; i < N_CHANNELS; i++) begin
                if (ch_valid[i]) begin
                    // A strobe on a channel that is emitted now is a fresh sample
                    pending_q[i] <= 1'b1;
                    if (pending_q[i] && !(comb_valid && sel_ch == PTR_W'(i))) begin
                        overrun <= 1'b1;
                    end
                end else if (comb_valid && sel_ch == PTR_W'(i)) begin
                    pending_q[i] <= 1'b0;
                end
            end
        end
    end

    // An emitted sample is used up unless its channel strobes again
    assert property (@(posedge clock) disable iff (rst)
        comb_valid && !ch_valid[sel_ch] |=> !pending_q[$past(sel_ch)]);

endmodule

// ==== logic/trigger_hub.sv ====
// **********************************************************************
// Trigger hub
// Level-crossing trigger that inhibits the stream while armed and
// re-arms when a frame has been completed
// **********************************************************************
`timescale 1ns/1ps

module trigger_hub (
    input  logic               clock,
    input  logic               rst,
    input  logic               enable,
    input  logic               comb_valid,
    input  logic               frame_done,
    input  scope_pkg::word_t   comb_data,
    input  scope_pkg::sample_t trig_level,
    input  logic [15:0]        trig_channel,
    output logic               cap_valid,
    output logic               trigger_out
);

    scope_pkg::trig_state_t state_q;
    scope_pkg::sample_t     prev_q;
    scope_pkg::sample_t     cur_sample;
    logic                   watched;
    logic                   crossing;

    assign cur_sample = comb_data[15:0];
    assign watched = comb_valid && (comb_data[31:16] == trig_channel);

    // Upward crossing: previous below the level, current at or above
    assign crossing = enable && (state_q == scope_pkg::ARMED) && watched &&
                      (prev_q < trig_level) && (cur_sample >= trig_level);

    // Inhibit gate on the combined stream
    assign cap_valid = comb_valid && enable && (state_q == scope_pkg::CAPTURING);

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q <= scope_pkg::ARMED;
            prev_q <= '1;
            trigger_out <= 1'b0;
        end else begin
            trigger_out <= crossing;
            if (watched) begin
                prev_q <= cur_sample;
            end
            if (!enable) begin
                state_q <= scope_pkg::ARMED;
            end else begin
                case (state_q)
                    scope_pkg::ARMED:
                        if (crossing) state_q <= scope_pkg::CAPTURING;
                    scope_pkg::CAPTURING:
                        if (frame_done) state_q <= scope_pkg::ARMED;
                endcase
            end
        end
    end

    // A trigger pulse marks the step from armed to capturing
    assert property (@(posedge clock) disable iff (rst)
        trigger_out |-> $past(state_q == scope_pkg::ARMED) &&
                        state_q == scope_pkg::CAPTURING);

endmodule

// ==== logic/frame_marker.sv ====
// **********************************************************************
// Frame marker
// Counts captured words and flags the last word of every frame
// **********************************************************************
`timescale 1ns/1ps

module frame_marker (
    input  logic             clock,
    input  logic             rst,
    input  logic             cap_valid,
    input  scope_pkg::word_t cap_data,
    input  logic [15:0]      frame_length,
    output logic             mark_valid,
    output logic             mark_last,
    output logic             frame_done,
    output scope_pkg::word_t mark_data
);

    logic [15:0] count_q;
    logic [15:0] count_base;
    logic [15:0] length_eff;

    // A zero length behaves as a one word frame
    assign length_eff = (frame_length == 16'd0) ? 16'd1 : frame_length;

    // The counter restarts from zero once a frame has been closed
    assign count_base = frame_done ? 16'd0 : count_q;

    assign frame_done = mark_valid && mark_last;

    always_ff @(posedge clock) begin
        if (rst) begin
            count_q <= '0;
            mark_valid <= 1'b0;
            mark_last <= 1'b0;
        end else begin
            mark_valid <= cap_valid;
            if (cap_valid) begin
                count_q <= count_base + 16'd1;
                mark_last <= (count_base + 16'd1) >= length_eff;
            end else begin
                count_q <= count_base;
                mark_last <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (cap_valid) begin
            mark_data <= cap_data;
        end
    end

endmodule

// ==== logic/sample_fifo.sv ====
// **********************************************************************
// Sample FIFO
// Buffers finished words with their last flag, written by strobe and
// drained through a valid/ready output
// **********************************************************************
`timescale 1ns/1ps

module sample_fifo #(
    parameter FIFO_DEPTH = 16
) (
    input  logic             clock,
    input  logic             rst,
    input  logic             wr_valid,
    input  logic             wr_last,
    input  logic             out_ready,
    input  scope_pkg::word_t wr_data,
    output logic             out_valid,
    output logic             out_last,
    output logic             overflow,
    output scope_pkg::word_t out_data
);

    localparam AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    scope_pkg::word_t mem_data [FIFO_DEPTH];
    logic             mem_last [FIFO_DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count_q;
    logic             full;
    logic             do_write;
    logic             do_read;

    assign full = (count_q == (AW+1)'(FIFO_DEPTH));
    assign do_write = wr_valid && !full;
    assign do_read = out_valid && out_ready;

    assign out_valid = (count_q != '0);
    assign out_data = mem_data[rd_ptr];
    assign out_last = mem_last[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem_data[wr_ptr] <= wr_data;
            mem_last[wr_ptr] <= wr_last;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count_q <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count_q <= count_q + 1'b1;
            end else if (do_read && !do_write) begin
                count_q <= count_q - 1'b1;
            end
            // Words arriving while full are lost
            if (wr_valid && full) begin
                overflow <= 1'b1;
            end
        end
    end

    assert property (@(posedge clock) disable iff (rst)
        count_q <= (AW+1)'(FIFO_DEPTH));

endmodule

// ==== logic/scope_control.sv ====
// **********************************************************************
// Scope control registers
// Write-only configuration bank on the simple bus
// **********************************************************************
`timescale 1ns/1ps

module scope_control #(
    parameter N_CHANNELS = 4
) (
    input  logic                clock,
    input  logic                rst,
    input  logic                sb_write,
    input  scope_pkg::reg_addr_t sb_addr,
    input  scope_pkg::word_t    sb_wdata,
    output logic [15:0]         frame_length,
    output logic                enable,
    output scope_pkg::sample_t  trig_level,
    output logic [15:0]         trig_channel
);

    logic channel_ok;

    // Channel selections outside the engine are rejected
    assign channel_ok = (sb_wdata < 32'(N_CHANNELS));

    always_ff @(posedge clock) begin
        if (rst) begin
            frame_length <= 16'd4;
            enable <= 1'b0;
            trig_level <= '0;
            trig_channel <= '0;
        end else if (sb_write) begin
            case (sb_addr)
                scope_pkg::ADDR_FRAME_LENGTH: begin
                    frame_length <= sb_wdata[15:0];
                end
                scope_pkg::ADDR_ENABLE: begin
                    enable <= sb_wdata[0];
                end
                scope_pkg::ADDR_TRIG_LEVEL: begin
                    trig_level <= sb_wdata[15:0];
                end
                scope_pkg::ADDR_TRIG_CHANNEL: begin
                    if (channel_ok) begin
                        trig_channel <= sb_wdata[15:0];
                    end
                end
                default: begin
                    // Unmapped addresses have no effect
                end
            endcase
        end
    end

endmodule

// ==== logic/scope_top.sv ====
// **********************************************************************
// Scope capture engine
// Combiner, trigger gate, frame marker and output FIFO, configured
// through a write-only register bank
// **********************************************************************
`timescale 1ns/1ps

module scope_top #(
    parameter N_CHANNELS = 4,
    parameter FIFO_DEPTH = 16
) (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 sb_write,
    input  logic                 out_ready,
    input  logic [N_CHANNELS-1:0] ch_valid,
    input  scope_pkg::sample_t   ch_data [N_CHANNELS],
    input  scope_pkg::reg_addr_t sb_addr,
    input  scope_pkg::word_t     sb_wdata,
    output logic                 out_valid,
    output logic                 out_last,
    output logic                 trigger_out,
    output logic                 overrun,
    output logic                 overflow,
    output scope_pkg::word_t     out_data
);

    logic               comb_valid;
    scope_pkg::word_t   comb_data;
    logic               cap_valid;
    logic               mark_valid;
    logic               mark_last;
    logic               frame_done;
    scope_pkg::word_t   mark_data;
    logic [15:0]        frame_length;
    logic               enable;
    scope_pkg::sample_t trig_level;
    logic [15:0]        trig_channel;

    channel_combiner #(
        .N_CHANNELS(N_CHANNELS)
    ) combiner (
        .clock(clock),
        .rst(rst),
        .ch_valid(ch_valid),
        .ch_data(ch_data),
        .comb_valid(comb_valid),
        .comb_data(comb_data),
        .overrun(overrun)
    );

    trigger_hub triggers (
        .clock(clock),
        .rst(rst),
        .enable(enable),
        .comb_valid(comb_valid),
        .frame_done(frame_done),
        .comb_data(comb_data),
        .trig_level(trig_level),
        .trig_channel(trig_channel),
        .cap_valid(cap_valid),
        .trigger_out(trigger_out)
    );

    // The gated stream carries the combiner data unchanged
    frame_marker marker (
        .clock(clock),
        .rst(rst),
        .cap_valid(cap_valid),
        .cap_data(comb_data),
        .frame_length(frame_length),
        .mark_valid(mark_valid),
        .mark_last(mark_last),
        .frame_done(frame_done),
        .mark_data(mark_data)
    );

    sample_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) out_fifo (
        .clock(clock),
        .rst(rst),
        .wr_valid(mark_valid),
        .wr_last(mark_last),
        .out_ready(out_ready),
        .wr_data(mark_data),
        .out_valid(out_valid),
        .out_last(out_last),
        .overflow(overflow),
        .out_data(out_data)
    );

    scope_control #(
        .N_CHANNELS(N_CHANNELS)
    ) control (
        .clock(clock),
        .rst(rst),
        .sb_write(sb_write),
        .sb_addr(sb_addr),
        .sb_wdata(sb_wdata),
        .frame_length(frame_length),
        .enable(enable),
        .trig_level(trig_level),
        .trig_channel(trig_channel)
    );

endmodule

// ==== verif/scope_tb.sv ====
// **********************************************************************
// Scope capture testbench
// Replays a command trace into the capture engine and checks every
// output word against the per-channel expectations of the trace
// **********************************************************************
`timescale 1ns/1ps

module scope_tb;

    localparam N_CHANNELS = 4;
    localparam TIMEOUT_CYCLES = 400;

    logic                  clock;
    logic                  rst;
    logic                  sb_write;
    logic                  out_ready;
    logic [N_CHANNELS-1:0] ch_valid;
    scope_pkg::sample_t    ch_data [N_CHANNELS];
    scope_pkg::reg_addr_t  sb_addr;
    scope_pkg::word_t      sb_wdata;
    logic                  out_valid;
    logic                  out_last;
    logic                  trigger_out;
    logic                  overrun;
    logic                  overflow;
    scope_pkg::word_t      out_data;

    // Expected words held as {last, channel, sample}
    logic [32:0] expected [$];
    logic        random_ready;
    logic [31:0] lfsr;
    int          errors;
    int          words_seen;
    int          trigger_count;

    scope_top #(.N_CHANNELS(N_CHANNELS), .FIFO_DEPTH(16)) DUT (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    always @(negedge clock) begin
        if (random_ready) begin
            out_ready = lfsr[0];
            lfsr = next_lfsr(lfsr);
        end else begin
            out_ready = 1'b1;
        end
    end

    always @(posedge clock) begin
        if (!rst && trigger_out) begin
            trigger_count++;
        end
    end

    // Only the oldest expected word of the same channel may match
    always @(posedge clock) begin : monitor
        int hit;
        if (!rst && out_valid && out_ready) begin
            words_seen++;
            hit = -1;
            for (int i = 0; i < expected.size(); i++) begin
                if (hit < 0 && expected[i][31:16] == out_data[31:16]) begin
                    hit = i;
                end
            end
            if (hit < 0) begin
                $display("** Error at %0t: unexpected word %h", $time, out_data);
                errors++;
            end else begin
                if (expected[hit][15:0] != out_data[15:0] || expected[hit][32] != out_last) begin
                    $display("** Error at %0t: channel %0d got %h last %b, expected %h last %b",
                             $time, out_data[31:16], out_data[15:0], out_last,
                             expected[hit][15:0], expected[hit][32]);
                    errors++;
                end
                expected.delete(hit);
            end
        end
    end

    task automatic bus_write(input scope_pkg::reg_addr_t addr, input scope_pkg::word_t data);
        sb_write = 1'b1;
        sb_addr = addr;
        sb_wdata = data;
        @(negedge clock);
        sb_write = 1'b0;
    endtask

    task automatic strobe(input logic [N_CHANNELS-1:0] mask, input logic [63:0] values);
        ch_valid = mask;
        for (int i = 0; i < N_CHANNELS; i++) begin
            ch_data[i] = values[16*i +: 16];
        end
        @(negedge clock);
        ch_valid = '0;
    endtask

    task automatic drain(output logic timed_out);
        int waited;
        waited = 0;
        while (expected.size() != 0 && waited < TIMEOUT_CYCLES) begin
            @(negedge clock);
            waited++;
        end
        timed_out = (expected.size() != 0);
        if (timed_out) begin
            $display("Timeout: %0d expected words did not arrive within %0d cycles",
                     expected.size(), TIMEOUT_CYCLES);
            errors++;
        end
        // Stray words still in flight get a chance to show up
        repeat (10) @(negedge clock);
    endtask

    initial begin
        int          fd;
        int          n;
        int          want;
        int          c;
        logic [7:0]  cmd;
        logic [31:0] a0;
        logic [31:0] a1;
        logic [31:0] a2;
        logic [31:0] a3;
        logic [31:0] a4;
        logic        abort;
        rst = 1'b1;
        sb_write = 1'b0;
        sb_addr = '0;
        sb_wdata = '0;
        ch_valid = '0;
        for (int i = 0; i < N_CHANNELS; i++) begin
            ch_data[i] = '0;
        end
        out_ready = 1'b1;
        random_ready = 1'b0;
        lfsr = 32'hc4d6_47d5;
        errors = 0;
        words_seen = 0;
        trigger_count = 0;
        abort = 1'b0;
        repeat (4) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        fd = $fopen("verif/scope_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file verif/scope_trace.txt");
            errors++;
            abort = 1'b1;
        end
        while (!abort && $fscanf(fd, " %c", cmd) == 1) begin
            n = 0;
            want = 0;
            case (cmd)
                "#": begin
                    c = $fgetc(fd);
                    while (c != 10 && c != -1) begin
                        c = $fgetc(fd);
                    end
                end
                "W": begin
                    want = 2;
                    n = $fscanf(fd, "%h %h", a0, a1);
                    bus_write(a0[3:0], a1);
                end
                "S": begin
                    want = 2;
                    n = $fscanf(fd, "%h %h", a0, a1);
                    strobe(N_CHANNELS'(1) << a0, {4{a1[15:0]}});
                end
                "P": begin
                    want = 5;
                    n = $fscanf(fd, "%h %h %h %h %h", a0, a1, a2, a3, a4);
                    strobe(a0[N_CHANNELS-1:0], {a4[15:0], a3[15:0], a2[15:0], a1[15:0]});
                end
                "I": begin
                    want = 1;
                    n = $fscanf(fd, "%h", a0);
                    repeat (a0) @(negedge clock);
                end
                "E": begin
                    want = 3;
                    n = $fscanf(fd, "%h %h %h", a0, a1, a2);
                    expected.push_back({a2[0], a0[15:0], a1[15:0]});
                end
                "R": begin
                    want = 1;
                    n = $fscanf(fd, "%h", a0);
                    random_ready = a0[0];
                end
                "D": drain(abort);
                "T": begin
                    want = 1;
                    n = $fscanf(fd, "%h", a0);
                    if (trigger_count != a0) begin
                        $display("** Error at %0t: %0d trigger pulses, expected %0d",
                                 $time, trigger_count, a0);
                        errors++;
                    end
                end
                "F": begin
                    want = 1;
                    n = $fscanf(fd, "%h", a0);
                    if ({overflow, overrun} != a0[1:0]) begin
                        $display("** Error at %0t: overflow %b overrun %b, expected %b",
                                 $time, overflow, overrun, a0[1:0]);
                        errors++;
                    end
                end
                default: begin
                    $display("Unknown trace command '%c'", cmd);
                    errors++;
                    abort = 1'b1;
                end
            endcase
            if (n != want) begin
                $display("Malformed trace line for command '%c'", cmd);
                errors++;
                abort = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (expected.size() != 0) begin
            $display("%0d expected words were never received", expected.size());
            errors++;
        end
        $display("Words received: %0d, errors: %0d", words_seen, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== verif/scope_trace.txt ====
# Hex operands: W addr data, S ch value, P mask v0 v1 v2 v3, I cycles,
# E ch value last, R random_ready, D drain, T trigger_pulses, F {overflow,overrun}
R 1
W 2 100
W 0 5
W 1 1
E 1 1 0
E 2 2 0
E 3 3 0
E 0 4 0
E 1 5 1
S 0 50
S 0 180
S 1 1
S 2 2
S 3 3
S 0 4
S 1 5
I 2
S 2 0bad
W 0 8
E 1 12 0
E 2 13 0
E 3 55 0
E 0 11 0
E 1 22 0
E 2 23 0
E 3 24 0
E 0 21 1
S 0 200
P f 11 12 13 14
S 3 55
I 4
P f 21 22 23 24
I 6
W 0 4
E 2 61 0
E 1 62 0
E 2 64 0
E 3 65 1
S 0 500
S 2 61
S 1 62
W 1 0
S 2 66
W 1 1
S 0 10
S 0 700
S 2 64
S 3 65
D
T 4
F 1

// ==== src.f ====
logic/scope_pkg.sv
logic/channel_combiner.sv
logic/trigger_hub.sv
logic/frame_marker.sv
logic/sample_fifo.sv
logic/scope_control.sv
logic/scope_top.sv
verif/scope_tb.sv
